/* project.f */
+incdir+include
rtl/raster_pkg.sv
rtl/raster_prim_decode.sv
rtl/raster_edge_eval.sv
rtl/raster_tile_walker.sv
rtl/raster_quad_queue.sv
rtl/raster_unit.sv
tests/raster_unit_checker.sv
tests/raster_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module raster_unit_tb -f project.f -o raster_unit_sim

# Raised error limit lets failed assertions be counted instead of stopping the run
./obj_dir/raster_unit_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without a reported failure"

/* tests/raster_unit_tb.sv */
`timescale 1ns/100ps
`include "raster_defs.svh"

module raster_unit_tb import raster_pkg::*; ();

    localparam logic [31:0] SEED = 32'h7a00eb35;
    localparam int WAIT_LIMIT = 4000;

    logic          clk;
    logic          reset;
    logic          in_valid;
    raster_cmd_u   in_cmd;
    logic          in_ready;
    logic          out_valid;
    raster_stamp_t out_stamp;
    logic          out_ready;
    logic          idle;

    raster_stamp_t exp_q [$];
    logic [31:0]   stim_rng;
    logic [31:0]   ready_rng;
    logic          backpressure = 1'b0;
    int            received = 0;
    int            value_errors = 0;
    int            other_errors = 0;

    raster_unit UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_cmd    (in_cmd),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_stamp (out_stamp),
        .out_ready (out_ready),
        .idle      (idle)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected stamps, quads in row-major order, empty quads dropped
    function automatic void predict_stamps(input raster_prim_t p);
        raster_stamp_t s;
        longint        v;
        int            px;
        int            py;
        for (int q = 0; q < `RASTER_QUADS_PER_TILE; q++) begin
            s.pos_x = p.tile_x + 12'((q % 4) * 2);
            s.pos_y = p.tile_y + 12'((q / 4) * 2);
            s.pid   = p.pid;
            s.mask  = 4'd0;
            for (int k = 0; k < 4; k++) begin
                // bit0 (x,y), bit1 (x+1,y), bit2 (x,y+1), bit3 (x+1,y+1)
                px = int'(s.pos_x) + (k % 2);
                py = int'(s.pos_y) + (k / 2);
                s.mask[k] = 1'b1;
                for (int e = 0; e < 3; e++) begin
                    v = longint'(p.edges[e].a) * px + longint'(p.edges[e].b) * py
                      + longint'(p.edges[e].c);
                    if (v < 0) begin
                        s.mask[k] = 1'b0;
                    end
                end
            end
            if (s.mask != 4'd0) begin
                exp_q.push_back(s);
            end
        end
    endfunction

    task automatic send_beat(input raster_cmd_u cmd);
        int waited;
        waited = 0;
        in_valid = 1'b1;
        in_cmd   = cmd;
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!in_ready) begin
            $display("Timed out at %0t: the DUT never took an input beat", $time);
            other_errors++;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic send_prim(input raster_prim_t p);
        raster_cmd_u cmd;
        predict_stamps(p);
        cmd = '0;
        cmd.hdr.pid    = p.pid;
        cmd.hdr.tile_x = p.tile_x;
        cmd.hdr.tile_y = p.tile_y;
        send_beat(cmd);
        for (int e = 0; e < 3; e++) begin
            cmd.coef = p.edges[e];
            send_beat(cmd);
        end
        in_valid = 1'b0;
    endtask

    // Three random half-planes passing near the tile centre
    task automatic send_random_prim(input logic [15:0] pid);
        raster_prim_t p;
        int a;
        int b;
        int off;
        p = '0;
        p.pid = pid;
        stim_rng = lcg_step(stim_rng);
        p.tile_x = 12'({stim_rng[28:24], 3'b000});
        p.tile_y = 12'({stim_rng[20:16], 3'b000});
        for (int e = 0; e < 3; e++) begin
            stim_rng = lcg_step(stim_rng);
            a   = int'(stim_rng[31:26]) - 32;
            b   = int'(stim_rng[25:20]) - 32;
            off = int'(stim_rng[19:13]) - 64;
            p.edges[e].a = 16'(a);
            p.edges[e].b = 16'(b);
            p.edges[e].c = 16'(off - a * (int'(p.tile_x) + 4) - b * (int'(p.tile_y) + 4));
        end
        send_prim(p);
    endtask

    task automatic wait_idle(input string what);
        int waited;
        waited = 0;
        while (!(idle && exp_q.size() == 0) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!(idle && exp_q.size() == 0)) begin
            $display("Timed out at %0t: the DUT did not finish %s", $time, what);
            other_errors++;
        end
    endtask

    initial begin
        out_ready = 1'b1;
        ready_rng = SEED;
        forever begin
            @(posedge clk);
            #2;
            ready_rng = lcg_step(ready_rng);
            out_ready = backpressure ? ready_rng[31] : 1'b1;
        end
    end

    // Compare each output transfer against the head of the expected queue
    initial begin
        raster_stamp_t want;
        forever begin
            @(negedge clk);
            if (!reset && out_valid && out_ready) begin
                received++;
                if (exp_q.size() == 0) begin
                    $display("[ERROR] %0t: unexpected stamp pid=%h", $time, out_stamp.pid);
                    value_errors++;
                end else begin
                    want = exp_q.pop_front();
                    if (out_stamp != want) begin
                        $display("[ERROR] %0t: got x=%0d y=%0d mask=%h pid=%h, want %0d %0d %h %h",
                                 $time, out_stamp.pos_x, out_stamp.pos_y, out_stamp.mask,
                                 out_stamp.pid, want.pos_x, want.pos_y, want.mask, want.pid);
                        value_errors++;
                    end
                end
            end
        end
    end

    initial begin
        raster_prim_t p;
        int           base;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_cmd   = '0;
        stim_rng = SEED;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;
        if (!idle || !in_ready || out_valid) begin
            $display("[ERROR] %0t: after reset idle=%b in_ready=%b out_valid=%b",
                     $time, idle, in_ready, out_valid);
            value_errors++;
        end

        // Whole tile inside all three edges
        p = '0;
        p.pid    = 16'h0101;
        p.tile_x = 12'd16;
        p.tile_y = 12'd24;
        p.edges[0] = '{a: 16'sd1, b: -16'sd1, c: 16'sd2000};
        p.edges[1] = '{a: -16'sd2, b: 16'sd0, c: 16'sd3000};
        p.edges[2] = '{a: 16'sd0, b: 16'sd3, c: 16'sd1000};
        base = received;
        send_prim(p);
        wait_idle("the full tile");
        if (received - base != 16) begin
            $display("[ERROR] %0t: full tile gave %0d stamps, want 16", $time, received - base);
            value_errors++;
        end

        // Tile entirely outside the second edge
        p.pid      = 16'h0202;
        p.edges[1] = '{a: -16'sd4, b: 16'sd0, c: 16'sd40};
        base = received;
        send_prim(p);
        wait_idle("the rejected tile");
        if (received != base) begin
            $display("[ERROR] %0t: rejected tile gave %0d stamps", $time, received - base);
            value_errors++;
        end

        for (int i = 0; i < 20; i++) begin
            send_random_prim(16'(16'h0400 + i));
        end
        wait_idle("the random primitives");

        backpressure = 1'b1;
        for (int i = 0; i < 20; i++) begin
            send_random_prim(16'(16'h0500 + i));
        end
        wait_idle("the primitives under back-pressure");

        // Back-to-back full tiles, each with its own pid
        for (int i = 0; i < 4; i++) begin
            p.pid      = 16'(16'h0600 + i);
            p.tile_x   = 12'(i * 8);
            p.edges[1] = '{a: -16'sd2, b: 16'sd0, c: 16'sd3000};
            send_prim(p);
        end
        wait_idle("the back-to-back primitives");

        $display("Closing: %0d value errors, %0d other errors, %0d assertion failures, %0d stamps",
                 value_errors, other_errors, UUT.port_checks.fail_count, received);
        if (value_errors == 0 && other_errors == 0 && UUT.port_checks.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tests/raster_unit_checker.sv */
`timescale 1ns/100ps

module raster_unit_checker import raster_pkg::*; (
    input logic          clk,
    input logic          reset,
    input logic          in_ready,
    input logic          idle,
    input logic          out_valid,
    input logic          out_ready,
    input raster_stamp_t out_stamp
);

    int fail_count = 0;

    // Held stamp stays put until the consumer takes it
    stamp_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_stamp))
        else begin
            fail_count++;
            $error("out_stamp or out_valid changed under back-pressure");
        end

    // Empty quads never leave the unit
    mask_nonzero: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_stamp.mask != 4'd0)
        else begin
            fail_count++;
            $error("stamp with an empty mask on the output");
        end

    // First cycle out of reset
    reset_state: assert property (@(posedge clk)
        $fell(reset) |-> in_ready && idle && !out_valid)
        else begin
            fail_count++;
            $error("in_ready or idle low, or out_valid high, after reset");
        end

endmodule

bind raster_unit raster_unit_checker port_checks (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .idle      (idle),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_stamp (out_stamp)
);

/* rtl/raster_unit.sv */
`timescale 1ns/100ps

module raster_unit import raster_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  raster_cmd_u   in_cmd,
    output logic          in_ready,
    output logic          out_valid,
    output raster_stamp_t out_stamp,
    input  logic          out_ready,
    output logic          idle
);

    logic               accept;
    logic               issue;
    raster_prim_t       prim;
    logic               decode_empty;
    logic               eval_valid;
    raster_prim_t       eval_prim;
    raster_eval_t [2:0] eval_origin;
    logic               push;
    raster_stamp_t      push_stamp;
    logic               full;
    logic               queue_empty;

    // Decode stage
    raster_prim_decode decode (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_cmd   (in_cmd),
        .in_ready (in_ready),
        .accept   (accept),
        .issue    (issue),
        .prim     (prim),
        .empty    (decode_empty)
    );

    // Execute stage
    raster_edge_eval edge_eval (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .prim        (prim),
        .eval_valid  (eval_valid),
        .eval_prim   (eval_prim),
        .eval_origin (eval_origin)
    );

    raster_tile_walker walker (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .eval_valid  (eval_valid),
        .eval_prim   (eval_prim),
        .eval_origin (eval_origin),
        .full        (full),
        .accept      (accept),
        .push        (push),
        .push_stamp  (push_stamp)
    );

    // Result stage
    raster_quad_queue result (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_stamp (push_stamp),
        .full       (full),
        .out_valid  (out_valid),
        .out_stamp  (out_stamp),
        .out_ready  (out_ready),
        .empty      (queue_empty)
    );

    assign idle = queue_empty && accept && decode_empty;

endmodule

/* rtl/raster_quad_queue.sv */
`timescale 1ns/100ps
`include "raster_defs.svh"

module raster_quad_queue import raster_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          push,
    input  raster_stamp_t push_stamp,
    output logic          full,
    output logic          out_valid,
    output raster_stamp_t out_stamp,
    input  logic          out_ready,
    output logic          empty
);

    localparam int DEPTH    = `RASTER_QUAD_FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = PTR_BITS + 1;
    localparam logic [PTR_BITS-1:0] LAST_PTR  = PTR_BITS'(DEPTH - 1);
    localparam logic [CNT_BITS-1:0] DEPTH_CNT = CNT_BITS'(DEPTH);

    raster_stamp_t       mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    assign full      = (count == DEPTH_CNT);
    assign empty     = (count == '0);
    assign out_valid = !empty;
    assign out_stamp = mem[rd_ptr];

    assign do_push = push && !full;
    assign do_pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_stamp;
        end
    end

endmodule

/* rtl/raster_tile_walker.sv */
`timescale 1ns/100ps
`include "raster_defs.svh"

module raster_tile_walker import raster_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  logic               eval_valid,
    input  raster_prim_t       eval_prim,
    input  raster_eval_t [2:0] eval_origin,
    input  logic               full,
    output logic               accept,
    output logic               push,
    output raster_stamp_t      push_stamp
);

    localparam logic [3:0] LAST_QUAD = 4'(`RASTER_QUADS_PER_TILE - 1);

    logic               pending;
    logic               busy;
    logic [3:0]         quad_cnt;
    logic               reject;
    raster_prim_t       cur_prim;
    raster_eval_t [2:0] cur_origin;
    logic [2:0]         qx;
    logic [2:0]         qy;
    logic [3:0]         mask;

    // Pixel test against all three edges, offset from the tile origin
    function automatic logic covered(raster_prim_t pr, raster_eval_t [2:0] org,
                                     logic [2:0] dx, logic [2:0] dy);
        raster_eval_t val;
        logic         hit;
        hit = 1'b1;
        for (int e = 0; e < 3; e++) begin
            val = org[e] + raster_eval_t'(pr.edges[e].a) * raster_eval_t'(dx)
                + raster_eval_t'(pr.edges[e].b) * raster_eval_t'(dy);
            if (val < 0) begin
                hit = 1'b0;
            end
        end
        return hit;
    endfunction

    // Tile is rejected when some edge is negative even at its best corner
    always_comb begin
        reject = 1'b0;
        for (int e = 0; e < 3; e++) begin
            if (eval_origin[e] + eval_prim.extents[e] < 0) begin
                reject = 1'b1;
            end
        end
    end

    assign accept = !busy && !pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending  <= 1'b0;
            busy     <= 1'b0;
            quad_cnt <= 4'd0;
        end else begin
            if (issue) begin
                pending <= 1'b1;
            end else if (eval_valid) begin
                pending <= 1'b0;
            end
            if (eval_valid && !reject) begin
                busy     <= 1'b1;
                quad_cnt <= 4'd0;
            end else if (busy && !full) begin
                quad_cnt <= quad_cnt + 4'd1;
                if (quad_cnt == LAST_QUAD) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (eval_valid) begin
            cur_prim   <= eval_prim;
            cur_origin <= eval_origin;
        end
    end

    // Quads in row-major order, four per row
    assign qx = {quad_cnt[1:0], 1'b0};
    assign qy = {quad_cnt[3:2], 1'b0};

    assign mask[0] = covered(cur_prim, cur_origin, qx,         qy);
    assign mask[1] = covered(cur_prim, cur_origin, qx | 3'd1,  qy);
    assign mask[2] = covered(cur_prim, cur_origin, qx,         qy | 3'd1);
    assign mask[3] = covered(cur_prim, cur_origin, qx | 3'd1,  qy | 3'd1);

    assign push             = busy && !full && (mask != 4'd0);
    assign push_stamp.pos_x = cur_prim.tile_x + {{(`RASTER_DIM_BITS-3){1'b0}}, qx};
    assign push_stamp.pos_y = cur_prim.tile_y + {{(`RASTER_DIM_BITS-3){1'b0}}, qy};
    assign push_stamp.mask  = mask;
    assign push_stamp.pid   = cur_prim.pid;

endmodule

/* rtl/raster_edge_eval.sv */
`timescale 1ns/100ps
`include "raster_defs.svh"

module raster_edge_eval import raster_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  raster_prim_t       prim,
    output logic               eval_valid,
    output raster_prim_t       eval_prim,
    output raster_eval_t [2:0] eval_origin
);

    localparam int LAT = `RASTER_MUL_LATENCY;

    logic [LAT-1:0]     valid_pipe;
    raster_prim_t       prim_pipe [LAT];
    raster_eval_t [2:0] s1_ax;
    raster_eval_t [2:0] s1_by;
    raster_eval_t [2:0] s1_c;
    raster_eval_t [2:0] s2_ab;
    raster_eval_t [2:0] s2_c;
    raster_eval_t [2:0] s3_val;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[LAT-2:0], issue};
        end
    end

    // Primitive rides alongside the multiply stages
    always_ff @(posedge clk) begin
        prim_pipe[0] <= prim;
        for (int i = 1; i < LAT; i++) begin
            prim_pipe[i] <= prim_pipe[i-1];
        end
    end

    // Stage 1 products, stage 2 partial sum, stage 3 final value
    always_ff @(posedge clk) begin
        for (int e = 0; e < 3; e++) begin
            s1_ax[e]  <= raster_eval_t'(prim.edges[e].a)
                       * raster_eval_t'($signed({1'b0, prim.tile_x}));
            s1_by[e]  <= raster_eval_t'(prim.edges[e].b)
                       * raster_eval_t'($signed({1'b0, prim.tile_y}));
            s1_c[e]   <= raster_eval_t'(prim.edges[e].c);
            s2_ab[e]  <= s1_ax[e] + s1_by[e];
            s2_c[e]   <= s1_c[e];
            s3_val[e] <= s2_ab[e] + s2_c[e];
        end
    end

    assign eval_valid  = valid_pipe[LAT-1];
    assign eval_prim   = prim_pipe[LAT-1];
    assign eval_origin = s3_val;

endmodule

/* rtl/raster_prim_decode.sv */
`timescale 1ns/100ps
`include "raster_defs.svh"

module raster_prim_decode import raster_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  raster_cmd_u  in_cmd,
    output logic         in_ready,
    input  logic         accept,
    output logic         issue,
    output raster_prim_t prim,
    output logic         empty
);

    logic [1:0]         beat_cnt;
    logic               hold;
    logic               beat_fire;
    raster_prim_t       prim_q;
    raster_eval_t [2:0] ext_next;

    // Largest value of a*dx + b*dy over the tile
    function automatic raster_eval_t edge_extent(raster_edge_t e);
        raster_eval_t pos_a;
        raster_eval_t pos_b;
        pos_a = (e.a > 0) ? raster_eval_t'(e.a) : '0;
        pos_b = (e.b > 0) ? raster_eval_t'(e.b) : '0;
        return (pos_a + pos_b) * raster_eval_t'(`RASTER_TILE_SIZE - 1);
    endfunction

    assign in_ready  = !hold;
    assign beat_fire = in_valid && in_ready;
    assign issue     = hold && accept;
    assign empty     = (beat_cnt == 2'd0) && !hold;
    assign prim      = prim_q;

    // Third edge is still on the input when the extents are computed
    assign ext_next[0] = edge_extent(prim_q.edges[0]);
    assign ext_next[1] = edge_extent(prim_q.edges[1]);
    assign ext_next[2] = edge_extent(in_cmd.coef);

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt <= 2'd0;
            hold     <= 1'b0;
        end else if (beat_fire) begin
            beat_cnt <= beat_cnt + 2'd1;
            if (beat_cnt == 2'd3) begin
                hold <= 1'b1;
            end
        end else if (issue) begin
            hold <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire) begin
            if (beat_cnt == 2'd0) begin
                prim_q.pid    <= in_cmd.hdr.pid;
                prim_q.tile_x <= in_cmd.hdr.tile_x;
                prim_q.tile_y <= in_cmd.hdr.tile_y;
            end else begin
                prim_q.edges[beat_cnt - 2'd1] <= in_cmd.coef;
            end
            if (beat_cnt == 2'd3) begin
                prim_q.extents <= ext_next;
            end
        end
    end

endmodule

/* rtl/raster_pkg.sv */
`include "raster_defs.svh"

package raster_pkg;

    // Signed edge value, also used for extents
    typedef logic signed [`RASTER_EVAL_BITS-1:0] raster_eval_t;

    // First beat of a primitive
    typedef struct packed {
        logic [15:0]                  pid;
        logic [`RASTER_DIM_BITS-1:0]  tile_x;
        logic [`RASTER_DIM_BITS-1:0]  tile_y;
        logic [7:0]                   reserved;
    } raster_hdr_t;

    // Edge equation a*x + b*y + c
    typedef struct packed {
        logic signed [`RASTER_DATA_BITS-1:0] a;
        logic signed [`RASTER_DATA_BITS-1:0] b;
        logic signed [`RASTER_DATA_BITS-1:0] c;
    } raster_edge_t;

    // One command word, header view on beat 0, edge view on beats 1 to 3
    typedef union packed {
        raster_hdr_t  hdr;
        raster_edge_t coef;
    } raster_cmd_u;

    typedef struct packed {
        logic [15:0]                  pid;
        logic [`RASTER_DIM_BITS-1:0]  tile_x;
        logic [`RASTER_DIM_BITS-1:0]  tile_y;
        raster_edge_t [2:0]           edges;
        raster_eval_t [2:0]           extents;
    } raster_prim_t;

    typedef struct packed {
        logic [`RASTER_DIM_BITS-1:0]  pos_x;
        logic [`RASTER_DIM_BITS-1:0]  pos_y;
        logic [3:0]                   mask;
        logic [15:0]                  pid;
    } raster_stamp_t;

endpackage

/* include/raster_defs.svh */
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// Pixel coordinate width
`define RASTER_DIM_BITS 12

// Signed edge coefficient width (a, b, c)
`define RASTER_DATA_BITS 16

// Signed edge value and extent width
`define RASTER_EVAL_BITS 32

// Tile geometry
`define RASTER_TILE_SIZE 8
`define RASTER_QUADS_PER_TILE 16

`define RASTER_MUL_LATENCY 3
`define RASTER_QUAD_FIFO_DEPTH 8

`endif
